// File: src/dds_pkg.sv
/* shared widths and burst control type for the tone generator
   table word is {coarse, slope}; phase bits below the fold field are dropped */
package dds_pkg;

   // phase accumulator and fcw
   localparam int PHASE_W = 32;

   // quarter-wave table geometry
   localparam int ROM_AW = 10;             // 1024 entries per quarter
   localparam int FINE_W = 14;             // offset between entries
   localparam int COARSE_W = 22;           // upper field of a table word
   localparam int SLOPE_W = 13;            // lower field
   localparam int ROM_DW = COARSE_W + SLOPE_W;

   // phase value to output sample
   // fold reg + table read + 4 interpolator stages
   localparam int PIPE_LAT = 6;

   // burst sequencing
   typedef enum logic [1:0] {
      st_idle,
      st_run,
      st_drain
   } burst_state_t;

endpackage

// File: src/burst_fsm.sv
/* burst sequencer; start is only honoured in idle, stop only in run
   drain holds busy until the last sample has left the pipeline */
`timescale 1ns/1ps

module burst_fsm import dds_pkg::*; (
   input  logic c,
   input  logic rst,
   input  logic start,       // strobe
   input  logic stop,        // strobe
   input  logic expired,     // from sample_timer
   output logic run,         // phase generator advances
   output logic clear,       // phase restart, first run cycle
   output logic load_len,
   output logic load_drain,
   output logic busy
);

   burst_state_t state;
   logic go;                 // first cycle of a burst

   always_ff @(posedge c) begin
      if (rst) begin
         state <= st_idle;
         go <= 1'b0;
         load_drain <= 1'b0;
      end else begin
         go <= 1'b0;          // both pulses last one cycle
         load_drain <= 1'b0;
         case (state)
            st_idle: begin
               if (start) begin
                  state <= st_run;
                  go <= 1'b1;
               end
            end
            st_run: begin
               // last sample or early cut, then flush the pipe
               if (expired || stop) begin
                  state <= st_drain;
                  load_drain <= 1'b1;
               end
            end
            st_drain: begin
               if (expired)
                  state <= st_idle;
            end
            default: state <= st_idle;
         endcase
      end
   end

   assign run = (state == st_run);
   assign clear = go;        // phase back to 0
   assign load_len = go;     // timer takes the burst length
   assign busy = (state != st_idle);

endmodule

// File: src/sample_timer.sv
/* down counter for burst length and drain; len of 0 runs as 1
   LEN_W must be wide enough to hold PIPE_LAT */
`timescale 1ns/1ps

module sample_timer import dds_pkg::*; #(
   parameter int LEN_W = 16
) (
   input  logic c,
   input  logic rst,
   input  logic load_len,
   input  logic load_drain,
   input  logic [LEN_W-1:0] len,
   output logic expired       // pulse in the final counted cycle
);

   logic [LEN_W-1:0] cnt;
   logic [LEN_W-1:0] ld_val;  // count taken on a load
   logic load;
   logic armed;               // counting down

   always_comb begin
      if (load_drain)
         ld_val = LEN_W'(PIPE_LAT);
      else if (len == '0)
         ld_val = LEN_W'(1);  // zero length treated as one sample
      else
         ld_val = len;
   end

   assign load = load_len | load_drain;

   // load cycle is the first counted one, so a count of 1 expires at once
   assign expired = load ? (ld_val == LEN_W'(1)) : (armed && cnt == LEN_W'(1));

   always_ff @(posedge c) begin
      if (rst) begin
         cnt <= '0;
         armed <= 1'b0;
      end else if (load) begin
         cnt <= ld_val - LEN_W'(1);
         armed <= (ld_val != LEN_W'(1));
      end else if (armed) begin
         cnt <= cnt - LEN_W'(1);
         if (cnt == LEN_W'(1))
            armed <= 1'b0;    // stale expiry can't fire later
      end
   end

endmodule

// File: src/phase_gen.sv
/* phase accumulator with quarter-wave fold; one register stage to the outputs
   the low PHASE_W-2-ROM_AW-FINE_W phase bits do not reach the table */
`timescale 1ns/1ps

module phase_gen import dds_pkg::*; (
   input  logic c,
   input  logic rst,
   input  logic run,
   input  logic clear,
   input  logic [PHASE_W-1:0] fcw,
   output logic [ROM_AW-1:0] rom_addr,
   output logic [FINE_W-1:0] fine,
   output logic pos,          // high for a positive result
   output logic vld
);

   localparam int FOLD_W = ROM_AW + FINE_W;

   logic [PHASE_W-1:0] acc;
   logic [PHASE_W-1:0] ph;    // phase of the current cycle
   logic [1:0] q;             // quadrant
   logic [FOLD_W-1:0] frac;   // position inside the quadrant
   logic [FOLD_W-1:0] folded;

   // clear forces the first sample of a burst onto phase 0
   assign ph = clear ? '0 : acc;
   assign q = ph[PHASE_W-1 -: 2];
   assign frac = ph[PHASE_W-3 -: FOLD_W];

   // odd quadrants run the table backwards
   assign folded = q[0] ? ~frac : frac;

   always_ff @(posedge c) begin
      if (rst) begin
         acc <= '0;
         vld <= 1'b0;
      end else begin
         acc <= run ? ph + fcw : ph;
         vld <= run;          // one sample per run cycle
      end
   end

   // fold register, no reset on payload
   always_ff @(posedge c) begin
      rom_addr <= folded[FOLD_W-1 -: ROM_AW];
      fine <= folded[FINE_W-1:0];
      pos <= ~(q[1] ^ q[0]);  // quadrants 0 and 3
   end

endmodule

// File: src/cos_rom.sv
/* quarter-wave cosine table, {coarse, slope} per entry, one-cycle read
   contents are computed when the design starts, no file is loaded */
`timescale 1ns/1ps

module cos_rom import dds_pkg::*; (
   input  logic c,
   input  logic [ROM_AW-1:0] rom_addr,
   output logic [ROM_DW-1:0] rom_d
);

   localparam int DEPTH = 1 << ROM_AW;
   localparam real PI = 3.14159265358979323846;

   logic [ROM_DW-1:0] rom [DEPTH];

   // rounded full-scale cosine at entry i, zero past the quarter
   function automatic logic [COARSE_W-1:0] coarse_at(input int i);
      real amp;
      real ang;
      amp = (2.0 ** COARSE_W) - 1.0;
      ang = real'(i) * PI / 2.0 / real'(DEPTH);
      if (i >= DEPTH)
         return '0;
      return COARSE_W'($rtoi(amp * $cos(ang) + 0.5));
   endfunction

   initial begin
      for (int i = 0; i < DEPTH; i++) begin
         // slope is the drop to the next entry, fits SLOPE_W at the steep end
         rom[i] = {coarse_at(i), SLOPE_W'(coarse_at(i) - coarse_at(i + 1))};
      end
   end

   always_ff @(posedge c) begin
      rom_d <= rom[rom_addr];
   end

endmodule

// File: src/cosine_int.sv
/* linear interpolator on the table output; four stages from rom_d to o
   NBO must not exceed COARSE_W+1, wider words would need sign extension */
`timescale 1ns/1ps

module cosine_int import dds_pkg::*; #(
   parameter int NBO = 23     // output sample bits
) (
   input  logic c,
   input  logic rst,
   input  logic pos,
   input  logic vld,
   input  logic [FINE_W-1:0] fine,
   input  logic [ROM_DW-1:0] rom_d,
   output logic signed [NBO-1:0] o,
   output logic o_valid
);

   localparam int PROD_W = SLOPE_W + FINE_W;
   localparam int SW = COARSE_W + 1;                     // signed full scale
   localparam logic [PROD_W-1:0] HALF = PROD_W'(1) << (FINE_W - 1);

   logic [FINE_W-1:0] fine_d;         // lines up with rom_d
   logic [PROD_W-1:0] prod_a;         // slope * fine, rounded
   logic [COARSE_W-1:0] coarse_a;
   logic [COARSE_W-1:0] mag_b;
   logic signed [SW-1:0] sv_c;
   logic [2:0] pos_sr;                // sign follows the data
   logic [PIPE_LAT-2:0] vld_sr;       // vld comes in one cycle after the phase

   always_ff @(posedge c) begin
      fine_d <= fine;
      pos_sr <= {pos_sr[1:0], pos};
      // stage a, product and coarse field
      prod_a <= rom_d[SLOPE_W-1:0] * fine_d + HALF;
      coarse_a <= rom_d[ROM_DW-1 -: COARSE_W];
      // stage b, step back from the entry toward the next one
      mag_b <= coarse_a - prod_a[PROD_W-1 -: SLOPE_W];
      // stage c, quadrant sign
      sv_c <= pos_sr[2] ? $signed({1'b0, mag_b}) : -$signed({1'b0, mag_b});
      // stage d
      o <= sv_c[SW-1 -: NBO];         // keep top bits
   end

   always_ff @(posedge c) begin
      if (rst)
         vld_sr <= '0;
      else
         vld_sr <= {vld_sr[PIPE_LAT-3:0], vld};
   end

   assign o_valid = vld_sr[PIPE_LAT-2];

endmodule

// File: src/dds_top.sv
/* burst tone generator; o follows a phase value by PIPE_LAT cycles
   no back-pressure, samples leave one per cycle while o_valid is high */
`timescale 1ns/1ps

module dds_top import dds_pkg::*; #(
   parameter int NBO = 23,
   parameter int LEN_W = 16
) (
   input  logic c,
   input  logic rst,
   input  logic start,
   input  logic stop,
   input  logic [LEN_W-1:0] len,         // samples per burst
   input  logic [PHASE_W-1:0] fcw,
   output logic signed [NBO-1:0] o,
   output logic o_valid,
   output logic busy
);

   // control
   logic run;
   logic clear;
   logic load_len;
   logic load_drain;
   logic expired;

   // data path
   logic [ROM_AW-1:0] rom_addr;
   logic [FINE_W-1:0] fine;
   logic pos;
   logic vld;
   logic [ROM_DW-1:0] rom_d;

   burst_fsm u_fsm (
      .c          (c),
      .rst        (rst),
      .start      (start),
      .stop       (stop),
      .expired    (expired),
      .run        (run),
      .clear      (clear),
      .load_len   (load_len),
      .load_drain (load_drain),
      .busy       (busy)
   );

   sample_timer #(.LEN_W(LEN_W)) u_timer (
      .c          (c),
      .rst        (rst),
      .load_len   (load_len),
      .load_drain (load_drain),
      .len        (len),
      .expired    (expired)
   );

   phase_gen u_phase (
      .c          (c),
      .rst        (rst),
      .run        (run),
      .clear      (clear),
      .fcw        (fcw),
      .rom_addr   (rom_addr),
      .fine       (fine),
      .pos        (pos),
      .vld        (vld)
   );

   cos_rom u_rom (
      .c          (c),
      .rom_addr   (rom_addr),
      .rom_d      (rom_d)
   );

   cosine_int #(.NBO(NBO)) u_interp (
      .c          (c),
      .rst        (rst),
      .pos        (pos),
      .vld        (vld),
      .fine       (fine),
      .rom_d      (rom_d),
      .o          (o),
      .o_valid    (o_valid)
   );

endmodule

// File: tests/dds_props.sv
/* control checks bound into dds_top
   burst state is taken from the fsm instance u_fsm */
`timescale 1ns/1ps

module dds_props import dds_pkg::*; (
   input logic c,
   input logic rst,
   input logic start,
   input logic busy,
   input logic o_valid,
   input logic clear,
   input burst_state_t state
);

   // every sample leaves inside a burst, drain included
   a_valid_busy: assert property (@(posedge c) disable iff (rst) o_valid |-> busy)
      else $error("o_valid high outside a burst");

   a_reset_idle: assert property (@(posedge c) rst |=> !busy)
      else $error("busy high in the cycle after reset");

   a_start_busy: assert property (@(posedge c) disable iff (rst)
      (start && !busy) |=> busy)
      else $error("start in idle did not raise busy");

   // phase restart only at the head of a burst
   a_no_clear_drain: assert property (@(posedge c) disable iff (rst)
      !(clear && state == st_drain))
      else $error("clear pulsed during drain");

endmodule

bind dds_top dds_props u_props (
   .c       (c),
   .rst     (rst),
   .start   (start),
   .busy    (busy),
   .o_valid (o_valid),
   .clear   (clear),
   .state   (u_fsm.state)
);

// File: tests/dds_tb.sv
/* bursts from a stimulus table, each sample held against a real-valued cosine
   o may sit up to 4 LSB off the model; random fcw rows use a fixed seed */
`timescale 1ns/1ps

module dds_tb import dds_pkg::*; ();

   localparam int NBO = 23;
   localparam int LEN_W = 16;
   localparam int NROWS = 7;
   localparam int TOL = 4;                // LSB allowed off the model
   localparam real TWO_PI = 6.28318530717958647692;

   logic c;
   logic rst;
   logic start;
   logic stop;
   logic [LEN_W-1:0] len;
   logic [PHASE_W-1:0] fcw;
   logic signed [NBO-1:0] o;
   logic o_valid;
   logic busy;

   // stimulus table, one burst per row
   logic [PHASE_W-1:0] t_fcw [NROWS];
   int t_len [NROWS];
   int t_stop [NROWS];                    // cycle after start carrying stop, 0 = none
   bit t_rest [NROWS];                    // extra start strobes while busy
   int t_exp [NROWS];                     // samples the burst must deliver

   int seed;
   int errors;
   int checks;
   int cycles;
   int limit;

   dds_top #(.NBO(NBO), .LEN_W(LEN_W)) UUT (
      .c       (c),
      .rst     (rst),
      .start   (start),
      .stop    (stop),
      .len     (len),
      .fcw     (fcw),
      .o       (o),
      .o_valid (o_valid),
      .busy    (busy)
   );

   always #2 c = ~c;                      // 4 ns period

   // run limit from the table lengths
   always @(posedge c) begin
      cycles = cycles + 1;
      if (cycles > limit) begin
         $display("timeout: run still going after %0d cycles", cycles);
         $display("Some tests failed");
         $finish;
      end
   end

   // full-scale cosine at phase k*fcw, rounded half away from zero
   function automatic int cos_model(input logic [PHASE_W-1:0] f, input int k);
      logic [PHASE_W-1:0] ph;
      real phr;
      real x;
      ph = f * PHASE_W'(k);               // wraps mod 2^32
      phr = ph;                            // unsigned, 0 up to 2^32-1
      x = (2.0 ** (NBO - 1) - 1.0) * $cos(TWO_PI * phr / 4294967296.0);
      if (x >= 0.0)
         return $rtoi(x + 0.5);
      return -$rtoi(0.5 - x);
   endfunction

   task automatic set_row(input int i, input logic [PHASE_W-1:0] f, input bit rnd,
                          input int n, input int stop_at, input bit rest, input int n_exp);
      if (rnd)
         t_fcw[i] = $random(seed);
      else
         t_fcw[i] = f;
      t_len[i] = n;
      t_stop[i] = stop_at;
      t_rest[i] = rest;
      t_exp[i] = n_exp;
   endtask

   task automatic run_burst(input int r);
      int cyc;
      int k;
      int got;
      int want;
      int diff;
      int row_err;
      cyc = 0;
      k = 0;
      row_err = 0;
      fcw = t_fcw[r];                      // held for the whole burst
      len = LEN_W'(t_len[r]);
      start = 1'b1;
      do begin
         @(posedge c);
         #1;
         cyc++;
         start = 1'b0;
         stop = (cyc == t_stop[r]);
         // one stray start in run, one in drain
         if (t_rest[r] && (cyc == 3 || cyc == t_len[r] + 2))
            start = 1'b1;
         if (cyc == 1) begin
            assert (busy) else begin
               $display("busy did not rise after start in row %0d", r);
               row_err++;
            end
         end
         if (o_valid) begin
            got = o;                       // sign extended
            want = cos_model(t_fcw[r], k);
            diff = got - want;
            checks++;
            assert (diff <= TOL && diff >= -TOL) else begin
               $display("[FAIL] o: got %h expected %h (row %0d sample %0d)", got, want, r, k);
               row_err++;
            end
            // phase of run cycle k+1 shows up PIPE_LAT later, one per cycle
            assert (cyc == PIPE_LAT + 1 + k) else begin
               $display("sample %0d of row %0d came in cycle %0d instead of cycle %0d",
                        k, r, cyc, PIPE_LAT + 1 + k);
               row_err++;
            end
            k++;
         end
      end while (busy);
      assert (k == t_exp[r]) else begin
         $display("[FAIL] o_valid count: got %h expected %h (row %0d)", k, t_exp[r], r);
         row_err++;
      end
      // busy drops in the cycle right after the last sample
      assert (cyc == PIPE_LAT + 1 + k) else begin
         $display("busy did not fall right after the last sample in row %0d (cycle %0d)",
                  r, cyc);
         row_err++;
      end
      // short quiet gap, nothing may leak out
      repeat (3) begin
         @(posedge c);
         #1;
         assert (!busy && !o_valid) else begin
            $display("output still active after the burst ended in row %0d", r);
            row_err++;
         end
      end
      errors += row_err;
      $display("row %0d: fcw %h len %0d stop %0d, %0d samples, %0d errors",
               r, t_fcw[r], t_len[r], t_stop[r], k, row_err);
   endtask

   initial begin
      c = 1'b0;
      rst = 1'b1;
      start = 1'b0;
      stop = 1'b0;
      len = '0;
      fcw = '0;
      seed = 53258;
      errors = 0;
      checks = 0;
      cycles = 0;
      //          fcw           rnd len stop rest exp
      set_row(0, 32'h0100_0000, 0, 20,  0,   0,  20);   // slow tone
      set_row(1, 32'h1000_0000, 0, 32,  0,   0,  32);   // 16 per turn, all quadrants
      set_row(2, 32'h0234_5678, 0, 40, 15,   0,  15);   // cut short by stop
      set_row(3, 32'h0080_0000, 0, 24,  0,   1,  24);   // start while busy
      set_row(4, 32'h0,         1, 30,  0,   0,  30);   // must restart at the peak
      set_row(5, 32'h0,         1, 25,  9,   0,   9);
      set_row(6, 32'h1000_0000, 0,  1,  0,   0,   1);   // single sample
      limit = 10;                          // reset and idle check
      for (int i = 0; i < NROWS; i++)
         limit += t_len[i] + PIPE_LAT + 20;

      repeat (2) @(posedge c);
      #1;
      rst = 1'b0;
      repeat (5) begin
         @(posedge c);
         #1;
         assert (!busy && !o_valid) else begin
            $display("busy or o_valid high before the first start");
            errors++;
         end
      end

      for (int r = 0; r < NROWS; r++)
         run_burst(r);

      $display("rows %0d, sample checks %0d, errors %0d", NROWS, checks, errors);
      if (errors == 0)
         $display("All tests passed");
      else
         $display("Some tests failed");
      $finish;
   end

endmodule

// File: sources.f
src/dds_pkg.sv
src/burst_fsm.sv
src/sample_timer.sv
src/phase_gen.sv
src/cos_rom.sv
src/cosine_int.sv
src/dds_top.sv
tests/dds_props.sv
tests/dds_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the dds testbench with Verilator, run it, judge the run from sim.log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   --top-module dds_tb -f sources.f

# an assertion stop gives a nonzero exit, the log check below decides
./obj_dir/Vdds_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "All tests passed" sim.log; then
   exit 0
fi
echo "simulation did not pass, see sim.log"
exit 1
